// File: Makefile
VERILATOR ?= verilator
TOP ?= tb_exec_subsys
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --assert -j 0

SRCS := $(shell grep -v '^+' compile.f) test/tb_ref_model.svh
BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

$(BIN): $(SRCS) compile.f
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f compile.f --Mdir $(BUILD_DIR)

run: $(BIN)
	./$(BIN) 2>&1 | tee $(LOG)
	@if grep -q "Simulation failed" $(LOG); then exit 1; fi
	@grep -q "Simulation completed successfully" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: compile.f
+incdir+test
design/core_pkg.sv
design/bus_pkg.sv
design/exec_result_if.sv
design/exec_stage.sv
design/result_fifo.sv
design/mem_stage.sv
design/exec_subsys_top.sv
test/tb_exec_subsys.sv

// File: design/bus_pkg.sv
`default_nettype none

package bus_pkg;

	typedef logic [3:0] byte_sel_t;

	typedef enum logic [1:0] {
		WIDTH_BYTE = 2'b00,
		WIDTH_HALF = 2'b01,
		WIDTH_WORD = 2'b10
	} mem_width_e;

	// little endian lanes, lsb is the low two byte address bits
	function automatic byte_sel_t sel_for(input mem_width_e width, input logic [1:0] lsb);
		case (width)
		WIDTH_BYTE: return byte_sel_t'(4'b0001 << lsb);
		WIDTH_HALF: return lsb[1] ? 4'b1100 : 4'b0011;
		default: return 4'b1111;
		endcase
	endfunction

endpackage

`default_nettype wire

// File: design/core_pkg.sv
`default_nettype none

package core_pkg;

	typedef logic [31:0] word_t;
	typedef logic [3:0] reg_sel_t;
	typedef logic [2:0] cr_sel_t;
	typedef logic [25:0] vec_base_t; // cr0 bits 31..6

	typedef enum logic [4:0] {
		ALU_ADD   = 5'd0,
		ALU_ADDC  = 5'd1,
		ALU_SUB   = 5'd2,
		ALU_SUBC  = 5'd3,
		ALU_LSL   = 5'd4,
		ALU_LSR   = 5'd5,
		ALU_AND   = 5'd6,
		ALU_XOR   = 5'd7,
		ALU_BIC   = 5'd8,
		ALU_BST   = 5'd9,
		ALU_OR    = 5'd10,
		ALU_COPYB = 5'd11,
		ALU_CMP   = 5'd12,
		ALU_MOVHI = 5'd13,
		ALU_ASR   = 5'd14,
		ALU_COPYA = 5'd15,
		ALU_GCR   = 5'd16
	} alu_opc_e;

	typedef enum logic [2:0] {
		BR_NEVER  = 3'b000,
		BR_NE     = 3'b001,
		BR_EQ     = 3'b010,
		BR_CC     = 3'b011,
		BR_CS     = 3'b100,
		BR_GT     = 3'b101,
		BR_LT     = 3'b110,
		BR_ALWAYS = 3'b111
	} branch_cond_e;

	typedef enum logic [1:0] {OP1_RA, OP1_RB, OP1_PC_PLUS_4} op1_sel_e;

	localparam cr_sel_t CR_VBASE = 3'd0;
	localparam cr_sel_t CR_PSR = 3'd1; // {irq_en, n, o, c, z}

endpackage

`default_nettype wire

// File: design/exec_result_if.sv
`timescale 1ns/1ns
`default_nettype none

interface exec_result_if
	import core_pkg::*, bus_pkg::*;
();

	logic valid;
	logic ready;
	logic is_load;
	logic is_store;
	mem_width_e width;
	word_t addr; // alu result
	word_t wdata; // store data or register write value
	reg_sel_t rd;
	logic wr_en;

	modport producer (
		output valid, is_load, is_store, width, addr, wdata, rd, wr_en,
		input ready
	);

	modport consumer (
		input valid, is_load, is_store, width, addr, wdata, rd, wr_en,
		output ready
	);

	modport monitor (
		input valid, ready, is_load, is_store, width, addr, wdata, rd, wr_en
	);

endinterface

`default_nettype wire

// File: design/exec_stage.sv
`timescale 1ns/1ns
`default_nettype none

module exec_stage
	import core_pkg::*, bus_pkg::*;
(
	input wire clk,
	input wire rst,
	input wire i_op_valid,
	output logic o_op_ready,
	input wire alu_opc_e i_alu_opc,
	input wire op1_sel_e i_op1_sel,
	input wire i_op2_rb,
	input wire word_t i_ra,
	input wire word_t i_rb,
	input wire word_t i_imm,
	input wire word_t i_pc_plus_4,
	input wire reg_sel_t i_rd_sel,
	input wire i_update_rd,
	input wire i_update_flags,
	input wire i_update_carry,
	input wire i_is_branch,
	input wire branch_cond_e i_branch_cond,
	input wire i_is_call,
	input wire i_mem_load,
	input wire i_mem_store,
	input wire mem_width_e i_mem_width,
	input wire cr_sel_t i_cr_sel,
	input wire i_write_cr,
	output logic o_branch_valid,
	output logic o_branch_taken,
	output word_t o_branch_target,
	exec_result_if.producer res
);

	word_t op1;
	word_t op2;
	word_t alu_q;
	logic alu_c;
	logic alu_n;
	logic alu_o;
	logic alu_z;
	logic c_flag;
	logic z_flag;
	logic n_flag;
	logic o_flag;
	logic irq_en;
	vec_base_t vec_base;
	logic [4:0] psr;
	word_t cr_rd_val;
	logic cond_met;
	logic accept;
	logic push;

	assign o_op_ready = !res.valid || res.ready;
	assign accept = i_op_valid && o_op_ready;
	// only ops with a memory access or a register write go downstream
	assign push = accept && (i_mem_load || i_mem_store || i_update_rd);

	always_comb begin
		case (i_op1_sel)
		OP1_RA: op1 = i_ra;
		OP1_RB: op1 = i_rb;
		default: op1 = i_pc_plus_4;
		endcase
	end

	assign op2 = i_op2_rb ? i_rb : i_imm;
	assign alu_z = (op1 ^ op2) == '0; // zero means operands equal
	assign psr = {irq_en, n_flag, o_flag, c_flag, z_flag};

	always_comb begin
		case (i_cr_sel)
		CR_VBASE: cr_rd_val = {vec_base, 6'b0};
		CR_PSR: cr_rd_val = {27'b0, psr};
		default: cr_rd_val = '0;
		endcase
	end

	always_comb begin
		alu_c = 1'b0;
		alu_n = 1'b0;
		alu_o = 1'b0;
		case (i_alu_opc)
		ALU_ADD: {alu_c, alu_q} = {1'b0, op1} + {1'b0, op2};
		ALU_ADDC: {alu_c, alu_q} = {1'b0, op1} + {1'b0, op2} + {32'b0, c_flag};
		ALU_SUB: {alu_c, alu_q} = {1'b0, op1} - {1'b0, op2};
		ALU_SUBC: {alu_c, alu_q} = {1'b0, op1} - {1'b0, op2} - {32'b0, c_flag};
		ALU_LSL: {alu_c, alu_q} = {1'b0, op1} << op2[4:0]; // carry is the last bit out
		ALU_LSR: alu_q = op1 >> op2[4:0];
		ALU_ASR: alu_q = word_t'($signed(op1) >>> op2[4:0]);
		ALU_AND: alu_q = op1 & op2;
		ALU_OR: alu_q = op1 | op2;
		ALU_XOR: alu_q = op1 ^ op2;
		ALU_BIC: alu_q = op1 & ~(word_t'(1) << op2[4:0]);
		ALU_BST: alu_q = op1 | (word_t'(1) << op2[4:0]);
		ALU_COPYA: alu_q = op1;
		ALU_COPYB: alu_q = op2;
		ALU_CMP: begin
			{alu_c, alu_q} = {1'b0, op1} - {1'b0, op2};
			alu_o = (op1[31] ^ op2[31]) && (alu_q[31] == op2[31]);
			alu_n = alu_q[31];
		end
		ALU_MOVHI: alu_q = {op2[15:0], 16'b0};
		ALU_GCR: alu_q = cr_rd_val;
		default: alu_q = '0;
		endcase
	end

	always_comb begin
		case (i_branch_cond)
		BR_ALWAYS: cond_met = 1'b1;
		BR_NE: cond_met = !z_flag;
		BR_EQ: cond_met = z_flag;
		BR_CC: cond_met = !c_flag;
		BR_CS: cond_met = c_flag;
		BR_GT: cond_met = !z_flag && (n_flag == o_flag);
		BR_LT: cond_met = n_flag != o_flag;
		default: cond_met = 1'b0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			z_flag <= 1'b0;
			c_flag <= 1'b0;
			n_flag <= 1'b0;
			o_flag <= 1'b0;
			irq_en <= 1'b0;
			vec_base <= '0;
		end else if (accept) begin
			if (i_write_cr && i_cr_sel == CR_PSR) begin
				{irq_en, n_flag, o_flag, c_flag, z_flag} <= i_ra[4:0]; // overrides alu flags
			end else begin
				if (i_update_flags) begin
					z_flag <= alu_z;
					n_flag <= alu_n;
					o_flag <= alu_o;
				end
				if (i_update_carry)
					c_flag <= alu_c;
			end
			if (i_write_cr && i_cr_sel == CR_VBASE)
				vec_base <= i_ra[31:6];
		end
	end

	always_ff @(posedge clk) begin
		if (rst)
			res.valid <= 1'b0;
		else if (accept)
			res.valid <= push;
		else if (res.ready)
			res.valid <= 1'b0;
	end

	always_ff @(posedge clk) begin
		if (push) begin
			res.is_load <= i_mem_load;
			res.is_store <= i_mem_store;
			res.width <= i_mem_width;
			res.addr <= alu_q;
			res.wdata <= i_is_call ? i_pc_plus_4 : i_mem_store ? i_rb : alu_q;
			res.rd <= i_rd_sel;
			res.wr_en <= i_update_rd;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			o_branch_valid <= 1'b0;
			o_branch_taken <= 1'b0;
		end else begin
			o_branch_valid <= accept && i_is_branch;
			o_branch_taken <= accept && i_is_branch && cond_met;
		end
	end

	always_ff @(posedge clk) begin
		if (accept && i_is_branch)
			o_branch_target <= alu_q;
	end

	a_ld_st_excl: assert property (@(posedge clk) disable iff (rst)
		accept |-> !(i_mem_load && i_mem_store));

	a_res_hold: assert property (@(posedge clk) disable iff (rst)
		res.valid && !res.ready |=> res.valid && $stable(res.addr) && $stable(res.wdata)
			&& $stable(res.rd) && $stable(res.wr_en));

endmodule

`default_nettype wire

// File: design/exec_subsys_top.sv
`timescale 1ns/1ns
`default_nettype none

module exec_subsys_top
	import core_pkg::*, bus_pkg::*;
#(
	parameter int FIFO_DEPTH = 4
) (
	input wire clk,
	input wire rst,
	input wire i_op_valid,
	output logic o_op_ready,
	input wire alu_opc_e i_alu_opc,
	input wire op1_sel_e i_op1_sel,
	input wire i_op2_rb,
	input wire word_t i_ra,
	input wire word_t i_rb,
	input wire word_t i_imm,
	input wire word_t i_pc_plus_4,
	input wire reg_sel_t i_rd_sel,
	input wire i_update_rd,
	input wire i_update_flags,
	input wire i_update_carry,
	input wire i_is_branch,
	input wire branch_cond_e i_branch_cond,
	input wire i_is_call,
	input wire i_mem_load,
	input wire i_mem_store,
	input wire mem_width_e i_mem_width,
	input wire cr_sel_t i_cr_sel,
	input wire i_write_cr,
	output logic o_branch_valid,
	output logic o_branch_taken,
	output word_t o_branch_target,
	output logic o_wb_cyc,
	output logic o_wb_stb,
	output logic o_wb_we,
	output word_t o_wb_adr,
	output byte_sel_t o_wb_sel,
	output word_t o_wb_dat,
	input wire word_t i_wb_dat,
	input wire i_wb_ack,
	output logic o_wr_valid,
	output reg_sel_t o_wr_rd,
	output word_t o_wr_data
);

	exec_result_if ex_to_fifo();
	exec_result_if fifo_to_mem();

	exec_stage u_exec (
		.clk, .rst,
		.i_op_valid, .o_op_ready,
		.i_alu_opc, .i_op1_sel, .i_op2_rb,
		.i_ra, .i_rb, .i_imm, .i_pc_plus_4,
		.i_rd_sel, .i_update_rd, .i_update_flags, .i_update_carry,
		.i_is_branch, .i_branch_cond, .i_is_call,
		.i_mem_load, .i_mem_store, .i_mem_width,
		.i_cr_sel, .i_write_cr,
		.o_branch_valid, .o_branch_taken, .o_branch_target,
		.res(ex_to_fifo.producer)
	);

	result_fifo #(
		.DEPTH(FIFO_DEPTH)
	) u_fifo (
		.clk, .rst,
		.wr(ex_to_fifo.consumer),
		.rd(fifo_to_mem.producer)
	);

	mem_stage u_mem (
		.clk, .rst,
		.req(fifo_to_mem.consumer),
		.o_wb_cyc, .o_wb_stb, .o_wb_we,
		.o_wb_adr, .o_wb_sel, .o_wb_dat,
		.i_wb_dat, .i_wb_ack,
		.o_wr_valid, .o_wr_rd, .o_wr_data
	);

endmodule

`default_nettype wire

// File: design/mem_stage.sv
`timescale 1ns/1ns
`default_nettype none

module mem_stage
	import core_pkg::*, bus_pkg::*;
(
	input wire clk,
	input wire rst,
	exec_result_if.consumer req,
	output logic o_wb_cyc,
	output logic o_wb_stb,
	output logic o_wb_we,
	output word_t o_wb_adr,
	output byte_sel_t o_wb_sel,
	output word_t o_wb_dat,
	input wire word_t i_wb_dat,
	input wire i_wb_ack,
	output logic o_wr_valid,
	output reg_sel_t o_wr_rd,
	output word_t o_wr_data
);

	typedef enum logic [1:0] {ST_IDLE, ST_BUS, ST_WB} state_e;

	state_e state;
	logic pop;
	logic we_q;
	logic is_load_q;
	logic wr_en_q;
	mem_width_e width_q;
	reg_sel_t rd_q;
	word_t adr_q;
	byte_sel_t sel_q;
	word_t dat_q;
	word_t wr_data_q;
	word_t st_data;
	word_t ld_shift;
	word_t ld_data;

	assign req.ready = state != ST_BUS; // no new entry while a bus cycle is open
	assign pop = req.valid && req.ready;

	always_comb begin
		case (req.width)
		WIDTH_BYTE: st_data = {4{req.wdata[7:0]}};
		WIDTH_HALF: st_data = {2{req.wdata[15:0]}};
		default: st_data = req.wdata;
		endcase
	end

	assign ld_shift = i_wb_dat >> {adr_q[1:0], 3'b000};

	always_comb begin
		case (width_q)
		WIDTH_BYTE: ld_data = {24'b0, ld_shift[7:0]};
		WIDTH_HALF: ld_data = {16'b0, ld_shift[15:0]};
		default: ld_data = i_wb_dat;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= ST_IDLE;
			we_q <= 1'b0;
			wr_en_q <= 1'b0;
		end else begin
			case (state)
			ST_BUS: begin
				if (i_wb_ack)
					state <= is_load_q ? ST_WB : ST_IDLE; // stores end at ack
			end
			default: begin
				if (pop)
					state <= (req.is_load || req.is_store) ? ST_BUS : ST_WB;
				else
					state <= ST_IDLE;
			end
			endcase
			if (pop) begin
				we_q <= req.is_store;
				wr_en_q <= req.wr_en;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (pop) begin
			is_load_q <= req.is_load;
			width_q <= req.width;
			rd_q <= req.rd;
			adr_q <= req.addr;
			sel_q <= sel_for(req.width, req.addr[1:0]);
			dat_q <= st_data;
			wr_data_q <= req.wdata;
		end else if (state == ST_BUS && i_wb_ack && is_load_q) begin
			wr_data_q <= ld_data;
		end
	end

	assign o_wb_cyc = state == ST_BUS;
	assign o_wb_stb = state == ST_BUS;
	assign o_wb_we = (state == ST_BUS) && we_q;
	assign o_wb_adr = adr_q;
	assign o_wb_sel = sel_q;
	assign o_wb_dat = dat_q;
	assign o_wr_valid = (state == ST_WB) && wr_en_q;
	assign o_wr_rd = rd_q;
	assign o_wr_data = wr_data_q;

	a_stb_cyc: assert property (@(posedge clk) disable iff (rst)
		o_wb_stb |-> o_wb_cyc);

	a_bus_hold: assert property (@(posedge clk) disable iff (rst)
		o_wb_stb && !i_wb_ack |=> o_wb_stb && $stable(o_wb_adr) && $stable(o_wb_sel)
			&& $stable(o_wb_dat) && $stable(o_wb_we));

	a_aligned: assert property (@(posedge clk) disable iff (rst)
		o_wb_stb |-> (width_q == WIDTH_WORD) ? (o_wb_adr[1:0] == 2'b00) :
			(width_q == WIDTH_HALF) ? !o_wb_adr[0] : 1'b1);

endmodule

`default_nettype wire

// File: design/result_fifo.sv
`timescale 1ns/1ns
`default_nettype none

module result_fifo
	import core_pkg::*, bus_pkg::*;
#(
	parameter int DEPTH = 4
) (
	input wire clk,
	input wire rst,
	exec_result_if.consumer wr,
	exec_result_if.producer rd
);

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic push;
	logic pop;

	logic is_load_q [DEPTH];
	logic is_store_q [DEPTH];
	mem_width_e width_q [DEPTH];
	word_t addr_q [DEPTH];
	word_t wdata_q [DEPTH];
	reg_sel_t rd_q [DEPTH];
	logic wr_en_q [DEPTH];

	// wraps at DEPTH so any depth works, not only powers of two
	function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
		return (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
	endfunction

	assign wr.ready = count != CNT_W'(DEPTH);
	assign rd.valid = count != '0;
	assign push = wr.valid && wr.ready;
	assign pop = rd.valid && rd.ready;

	always_ff @(posedge clk) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (push)
				wr_ptr <= ptr_inc(wr_ptr);
			if (pop)
				rd_ptr <= ptr_inc(rd_ptr);
			if (push && !pop)
				count <= count + 1'b1;
			else if (pop && !push)
				count <= count - 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (push) begin
			is_load_q[wr_ptr] <= wr.is_load;
			is_store_q[wr_ptr] <= wr.is_store;
			width_q[wr_ptr] <= wr.width;
			addr_q[wr_ptr] <= wr.addr;
			wdata_q[wr_ptr] <= wr.wdata;
			rd_q[wr_ptr] <= wr.rd;
			wr_en_q[wr_ptr] <= wr.wr_en;
		end
	end

	// oldest entry falls through to the output
	assign rd.is_load = is_load_q[rd_ptr];
	assign rd.is_store = is_store_q[rd_ptr];
	assign rd.width = width_q[rd_ptr];
	assign rd.addr = addr_q[rd_ptr];
	assign rd.wdata = wdata_q[rd_ptr];
	assign rd.rd = rd_q[rd_ptr];
	assign rd.wr_en = wr_en_q[rd_ptr];

	a_count_max: assert property (@(posedge clk) disable iff (rst)
		count <= CNT_W'(DEPTH));

	a_pop_nonempty: assert property (@(posedge clk) disable iff (rst)
		pop && !push |=> count == $past(count) - 1'b1 && $past(count) != '0);

endmodule

`default_nettype wire

// File: test/tb_ref_model.svh
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

logic m_z;
logic m_c;
logic m_n;
logic m_o;
logic m_irq;
logic [25:0] m_vbase;
word_t model_mem [256];
logic [35:0] exp_wb_q [$]; // {rd, data}
logic [32:0] exp_br_q [$]; // {taken, target}
logic [68:0] exp_bus_q [$]; // {we, adr, sel, dat}
int n_wb_exp;
int n_st_exp;

// every bit of the word index shapes the fill
function automatic word_t mem_pattern(input int idx);
	logic [7:0] a;
	a = 8'(idx);
	return {a, ~a, a ^ 8'h5a, a + 8'hc3};
endfunction

function automatic logic cond_holds(input branch_cond_e cond);
	case (cond)
	BR_NE: return !m_z;
	BR_EQ: return m_z;
	BR_CC: return !m_c;
	BR_CS: return m_c;
	BR_GT: return !m_z && (m_n == m_o);
	BR_LT: return m_n != m_o;
	BR_ALWAYS: return 1'b1;
	default: return 1'b0;
	endcase
endfunction

function automatic word_t model_alu(input alu_opc_e opc, input word_t a, input word_t b,
	input cr_sel_t sel, output logic c, output logic n, output logic o);
	logic [32:0] wide;
	word_t diff;
	int sh;
	sh = int'(b[4:0]);
	c = 1'b0;
	n = 1'b0;
	o = 1'b0;
	case (opc)
	ALU_ADD, ALU_ADDC: begin
		wide = {1'b0, a} + {1'b0, b} + ((opc == ALU_ADDC) ? 33'(m_c) : 33'd0);
		c = wide[32];
		return wide[31:0];
	end
	ALU_SUB: begin
		c = a < b; // borrow
		return a - b;
	end
	ALU_SUBC: begin
		c = {1'b0, a} < ({1'b0, b} + 33'(m_c));
		return a - b - 32'(m_c);
	end
	ALU_LSL: begin
		c = (sh == 0) ? 1'b0 : a[32 - sh];
		return a << sh;
	end
	ALU_LSR: return a >> sh;
	ALU_ASR: return word_t'($signed(a) >>> sh);
	ALU_AND: return a & b;
	ALU_OR: return a | b;
	ALU_XOR: return a ^ b;
	ALU_BIC: return a & ~(32'h1 << sh);
	ALU_BST: return a | (32'h1 << sh);
	ALU_COPYA: return a;
	ALU_COPYB: return b;
	ALU_CMP: begin
		diff = a - b;
		c = a < b;
		n = diff[31];
		o = (a[31] != b[31]) && (diff[31] != a[31]);
		return diff;
	end
	ALU_MOVHI: return b << 16;
	ALU_GCR: begin
		if (sel == 3'd0)
			return {m_vbase, 6'b0};
		else if (sel == 3'd1)
			return {27'b0, m_irq, m_n, m_o, m_c, m_z};
		return '0;
	end
	default: return '0;
	endcase
endfunction

`endif

// File: test/tb_exec_subsys.sv
`timescale 1ns/1ns
`default_nettype none

module tb_exec_subsys
	import core_pkg::*, bus_pkg::*;
;

	localparam int NUM_OPS = 400;
	localparam int TIMEOUT = NUM_OPS * 8 + 200;
	localparam alu_opc_e ALU_LIST [16] = '{ALU_ADD, ALU_ADDC, ALU_SUB, ALU_SUBC, ALU_LSL,
		ALU_LSR, ALU_ASR, ALU_AND, ALU_OR, ALU_XOR, ALU_BIC, ALU_BST, ALU_COPYA, ALU_COPYB,
		ALU_CMP, ALU_MOVHI};

	logic clk;
	logic rst;
	logic i_op_valid;
	logic o_op_ready;
	alu_opc_e i_alu_opc;
	op1_sel_e i_op1_sel;
	logic i_op2_rb;
	word_t i_ra;
	word_t i_rb;
	word_t i_imm;
	word_t i_pc_plus_4;
	reg_sel_t i_rd_sel;
	logic i_update_rd;
	logic i_update_flags;
	logic i_update_carry;
	logic i_is_branch;
	branch_cond_e i_branch_cond;
	logic i_is_call;
	logic i_mem_load;
	logic i_mem_store;
	mem_width_e i_mem_width;
	cr_sel_t i_cr_sel;
	logic i_write_cr;
	logic o_branch_valid;
	logic o_branch_taken;
	word_t o_branch_target;
	logic o_wb_cyc;
	logic o_wb_stb;
	logic o_wb_we;
	word_t o_wb_adr;
	byte_sel_t o_wb_sel;
	word_t o_wb_dat;
	word_t i_wb_dat;
	logic i_wb_ack;
	logic o_wr_valid;
	reg_sel_t o_wr_rd;
	word_t o_wr_data;

	word_t slave_mem [256];
	int err_val;
	int err_proto;
	int cycles;
	int n_wb_seen;
	int n_st_seen;
	int wait_cnt;
	logic slave_busy;

	`include "tb_ref_model.svh"

	exec_subsys_top dut0 (.*);

	task automatic check_word(input string name, input word_t exp, input word_t act);
		assert (exp == act) else begin
			err_val++;
			$display("error %0t %s expected %h actual %h", $time, name, exp, act);
		end
	endtask

	task automatic model_accept();
		word_t a;
		word_t b;
		word_t q;
		word_t val;
		logic c;
		logic n;
		logic o;
		int idx;
		int lane;
		byte_sel_t sel;
		a = (i_op1_sel == OP1_RA) ? i_ra : (i_op1_sel == OP1_RB) ? i_rb : i_pc_plus_4;
		b = i_op2_rb ? i_rb : i_imm;
		q = model_alu(i_alu_opc, a, b, i_cr_sel, c, n, o);
		if (i_is_branch)
			exp_br_q.push_back({cond_holds(i_branch_cond), q});
		idx = int'(q[9:2]);
		lane = int'(q[1:0]);
		sel = sel_for(i_mem_width, q[1:0]);
		if (i_mem_store) begin
			val = (i_mem_width == WIDTH_BYTE) ? {4{i_rb[7:0]}} :
				(i_mem_width == WIDTH_HALF) ? {2{i_rb[15:0]}} : i_rb;
			for (int k = 0; k < 4; k++)
				if (sel[k])
					model_mem[idx][8*k +: 8] = val[8*k +: 8];
			exp_bus_q.push_back({1'b1, q, sel, val});
			n_st_exp++;
		end else if (i_mem_load) begin
			exp_bus_q.push_back({1'b0, q, sel, 32'h0});
			val = model_mem[idx] >> (8 * lane);
			if (i_mem_width == WIDTH_BYTE)
				val = val & 32'h0000_00ff;
			else if (i_mem_width == WIDTH_HALF)
				val = val & 32'h0000_ffff;
			if (i_update_rd) begin
				exp_wb_q.push_back({i_rd_sel, val});
				n_wb_exp++;
			end
		end else if (i_update_rd) begin
			exp_wb_q.push_back({i_rd_sel, i_is_call ? i_pc_plus_4 : q});
			n_wb_exp++;
		end
		if (i_write_cr && i_cr_sel == 3'd1) begin
			{m_irq, m_n, m_o, m_c, m_z} = i_ra[4:0]; // psr write wins over alu flags
		end else begin
			if (i_update_flags) begin
				m_z = a == b;
				m_n = n;
				m_o = o;
			end
			if (i_update_carry)
				m_c = c;
		end
		if (i_write_cr && i_cr_sel == 3'd0)
			m_vbase = i_ra[31:6];
	endtask

	task automatic clear_op();
		i_alu_opc = ALU_ADD;
		i_op1_sel = OP1_RA;
		i_op2_rb = 1'b0;
		i_update_rd = 1'b0;
		i_update_flags = 1'b0;
		i_update_carry = 1'b0;
		i_is_branch = 1'b0;
		i_branch_cond = BR_NEVER;
		i_is_call = 1'b0;
		i_mem_load = 1'b0;
		i_mem_store = 1'b0;
		i_mem_width = WIDTH_WORD;
		i_cr_sel = 3'd0;
		i_write_cr = 1'b0;
	endtask

	task automatic randomize_op();
		int kind;
		logic [1:0] off;
		clear_op();
		kind = int'($urandom % 10);
		i_ra = $urandom;
		i_rb = $urandom;
		i_imm = (($urandom % 2) == 0) ? 32'($urandom % 40) : $urandom; // small shifts often
		i_pc_plus_4 = {30'($urandom), 2'b00};
		i_rd_sel = 4'($urandom);
		if (kind <= 3) begin
			i_alu_opc = ALU_LIST[$urandom % 16];
			i_op1_sel = op1_sel_e'(2'($urandom % 3));
			i_op2_rb = 1'($urandom);
			i_update_rd = ($urandom % 8) != 0;
			i_update_flags = 1'($urandom);
			i_update_carry = 1'($urandom);
		end else if (kind == 4) begin
			i_is_branch = 1'b1;
			i_branch_cond = branch_cond_e'(3'($urandom));
			i_op1_sel = OP1_PC_PLUS_4;
			i_is_call = 1'($urandom);
			i_update_rd = i_is_call;
		end else if (kind == 5) begin
			i_write_cr = 1'b1;
			i_cr_sel = (($urandom % 4) == 0) ? 3'd2 : 3'($urandom % 2);
		end else if (kind == 6) begin
			i_alu_opc = ALU_GCR;
			i_cr_sel = 3'($urandom % 3);
			i_update_rd = 1'b1;
		end else begin
			i_mem_width = mem_width_e'(2'($urandom % 3));
			off = (i_mem_width == WIDTH_BYTE) ? 2'($urandom) :
				(i_mem_width == WIDTH_HALF) ? {1'($urandom), 1'b0} : 2'b00;
			i_ra = {22'b0, 8'($urandom), off};
			i_imm = '0;
			i_mem_store = kind == 7;
			i_mem_load = kind != 7;
			i_update_rd = kind != 7;
		end
	endtask

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// wishbone slave with random wait states
	always @(posedge clk) begin
		logic [68:0] e;
		#1;
		if (i_wb_ack) begin
			i_wb_ack = 1'b0;
		end else if (o_wb_cyc && o_wb_stb) begin
			if (!slave_busy) begin
				slave_busy = 1'b1;
				wait_cnt = int'($urandom % 5);
			end else if (wait_cnt != 0) begin
				wait_cnt--;
			end else begin
				slave_busy = 1'b0;
				i_wb_ack = 1'b1;
				i_wb_dat = slave_mem[o_wb_adr[9:2]];
				if (o_wb_we) begin
					for (int k = 0; k < 4; k++)
						if (o_wb_sel[k])
							slave_mem[o_wb_adr[9:2]][8*k +: 8] = o_wb_dat[8*k +: 8];
					n_st_seen++;
				end
				if (exp_bus_q.size() == 0) begin
					err_proto++;
					$display("bus cycle at %0t with no access expected", $time);
				end else begin
					e = exp_bus_q.pop_front();
					check_word("o_wb_we", 32'(e[68]), 32'(o_wb_we));
					check_word("o_wb_adr", e[67:36], o_wb_adr);
					check_word("o_wb_sel", 32'(e[35:32]), 32'(o_wb_sel));
					if (e[68])
						check_word("o_wb_dat", e[31:0], o_wb_dat);
				end
			end
		end
	end

	always @(posedge clk) begin
		logic [35:0] w;
		logic [32:0] br;
		#1;
		cycles++;
		if (cycles <= 11) begin
			assert (!o_wb_cyc && !o_wb_stb && !o_wr_valid && !o_branch_valid) else begin
				err_proto++;
				$display("outputs active during or right after reset at %0t", $time);
			end
		end
		if (o_wr_valid) begin
			n_wb_seen++;
			if (exp_wb_q.size() == 0) begin
				err_proto++;
				$display("writeback at %0t with none expected", $time);
			end else begin
				w = exp_wb_q.pop_front();
				check_word("o_wr_rd", 32'(w[35:32]), 32'(o_wr_rd));
				check_word("o_wr_data", w[31:0], o_wr_data);
			end
		end
		if (o_branch_valid) begin
			if (exp_br_q.size() == 0) begin
				err_proto++;
				$display("branch result at %0t with no branch expected", $time);
			end else begin
				br = exp_br_q.pop_front();
				check_word("o_branch_taken", 32'(br[32]), 32'(o_branch_taken));
				check_word("o_branch_target", br[31:0], o_branch_target);
			end
		end
		if (cycles >= TIMEOUT) begin
			$display("timeout waiting for writebacks");
			$display("errors: value %0d, protocol %0d", err_val, err_proto);
			$display("Simulation failed");
			$finish;
		end
	end

	initial begin
		logic rdy;
		void'($urandom(32'he7f2_e0a8));
		err_val = 0;
		err_proto = 0;
		cycles = 0;
		n_wb_seen = 0;
		n_st_seen = 0;
		n_wb_exp = 0;
		n_st_exp = 0;
		slave_busy = 1'b0;
		wait_cnt = 0;
		{m_z, m_c, m_n, m_o, m_irq} = '0;
		m_vbase = '0;
		for (int i = 0; i < 256; i++) begin
			model_mem[i] = mem_pattern(i);
			slave_mem[i] = mem_pattern(i);
		end
		rst = 1'b1;
		i_op_valid = 1'b0;
		i_ra = '0;
		i_rb = '0;
		i_imm = '0;
		i_pc_plus_4 = '0;
		i_rd_sel = '0;
		i_wb_dat = '0;
		i_wb_ack = 1'b0;
		clear_op();
		repeat (10) @(posedge clk);
		#1 rst = 1'b0;
		@(posedge clk); // one quiet cycle right after reset
		#1;
		for (int i = 0; i < NUM_OPS; i++) begin
			if (($urandom % 4) == 0) begin
				i_op_valid = 1'b0;
				@(posedge clk);
				#1;
			end
			randomize_op();
			i_op_valid = 1'b1;
			do begin
				@(negedge clk);
				rdy = o_op_ready;
				if (rdy)
					model_accept();
				@(posedge clk);
				#1;
			end while (!rdy);
			i_op_valid = 1'b0;
		end
		while (exp_wb_q.size() != 0 || exp_br_q.size() != 0 || exp_bus_q.size() != 0)
			@(posedge clk);
		repeat (5) @(posedge clk);
		#1;
		assert (n_wb_seen == n_wb_exp && n_st_seen == n_st_exp) else begin
			err_proto++;
			$display("count mismatch: writebacks %0d of %0d, stores %0d of %0d",
				n_wb_seen, n_wb_exp, n_st_seen, n_st_exp);
		end
		$display("errors: value %0d, protocol %0d", err_val, err_proto);
		if (err_val == 0 && err_proto == 0)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

`default_nettype wire
